//--- build.f
+incdir+tests
logic/filter_pkg.sv
logic/line_buffer.sv
logic/window_3x3.sv
logic/laplace_kernel.sv
logic/filter_top.sv
tests/filter_sva.sv
tests/filter_tb.sv

//--- logic/filter_pkg.sv
//**************************************************
// 3x3 filter shared definitions
// line geometry, RGB565 pixel and channel types, kernel weights
//**************************************************
`default_nettype none

package filter_pkg;

	// pixels per line
	localparam int line_len = 720;

	// counter widths, column holds 0..719
	localparam int col_w = 10;
	// rows up to 4095 before the counter wraps
	localparam int row_w = 12;

	// RGB565, red in [15:11], green in [10:5], blue in [4:0]
	typedef logic [15:0] pixel_t;

	// red and blue share the 5-bit width
	typedef logic [4:0] red_t;
	typedef logic [5:0] green_t;

	typedef logic [col_w-1:0] col_t;
	typedef logic [row_w-1:0] row_t;

	// kernel weights
	// | corner | edge   | corner |
	// | edge   | centre | edge   |
	// | corner | edge   | corner |
	// default is the 4-neighbour laplacian
	localparam int w_centre = -4;
	localparam int w_edge = 1;
	localparam int w_corner = 0;

endpackage

`default_nettype wire

//--- logic/filter_top.sv
//**************************************************
// streaming 3x3 RGB565 image filter
// line buffer, window and kernel, three stages deep
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module filter_top (
	input wire clk,
	input wire reset,
	input wire filter_pkg::pixel_t pixel_in,
	input wire pix_valid,
	input wire frame_start,
	output filter_pkg::pixel_t pixel_out,
	output logic out_valid
);

	// line buffer taps
	logic tap_valid;
	logic tap_interior;
	filter_pkg::pixel_t tap_cur;
	filter_pkg::pixel_t tap_up1;
	filter_pkg::pixel_t tap_up2;

	// window contents
	logic win_valid;
	filter_pkg::pixel_t win_00;
	filter_pkg::pixel_t win_01;
	filter_pkg::pixel_t win_02;
	filter_pkg::pixel_t win_10;
	filter_pkg::pixel_t win_11;
	filter_pkg::pixel_t win_12;
	filter_pkg::pixel_t win_20;
	filter_pkg::pixel_t win_21;
	filter_pkg::pixel_t win_22;

	// stage 1, row history and counters
	line_buffer u_line_buffer (
		.clk          (clk),
		.reset        (reset),
		.pixel_in     (pixel_in),
		.pix_valid    (pix_valid),
		.frame_start  (frame_start),
		.tap_valid    (tap_valid),
		.tap_cur      (tap_cur),
		.tap_up1      (tap_up1),
		.tap_up2      (tap_up2),
		.tap_interior (tap_interior)
	);

	// stage 2
	window_3x3 u_window_3x3 (
		.clk          (clk),
		.reset        (reset),
		.tap_valid    (tap_valid),
		.tap_cur      (tap_cur),
		.tap_up1      (tap_up1),
		.tap_up2      (tap_up2),
		.tap_interior (tap_interior),
		.win_valid    (win_valid),
		.win_00       (win_00),
		.win_01       (win_01),
		.win_02       (win_02),
		.win_10       (win_10),
		.win_11       (win_11),
		.win_12       (win_12),
		.win_20       (win_20),
		.win_21       (win_21),
		.win_22       (win_22)
	);

	// stage 3, weighted sum and output register
	laplace_kernel u_laplace_kernel (
		.clk       (clk),
		.reset     (reset),
		.win_valid (win_valid),
		.win_00    (win_00),
		.win_01    (win_01),
		.win_02    (win_02),
		.win_10    (win_10),
		.win_11    (win_11),
		.win_12    (win_12),
		.win_20    (win_20),
		.win_21    (win_21),
		.win_22    (win_22),
		.pixel_out (pixel_out),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

//--- logic/laplace_kernel.sv
//**************************************************
// 3x3 kernel stage
// per-channel weighted sum, wrapped and repacked to RGB565
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module laplace_kernel (
	input wire clk,
	input wire reset,
	input wire win_valid,
	input wire filter_pkg::pixel_t win_00,
	input wire filter_pkg::pixel_t win_01,
	input wire filter_pkg::pixel_t win_02,
	input wire filter_pkg::pixel_t win_10,
	input wire filter_pkg::pixel_t win_11,
	input wire filter_pkg::pixel_t win_12,
	input wire filter_pkg::pixel_t win_20,
	input wire filter_pkg::pixel_t win_21,
	input wire filter_pkg::pixel_t win_22,
	output filter_pkg::pixel_t pixel_out,
	output logic out_valid
);

	// signed sums per channel, 0 red, 1 green, 2 blue
	int ch_sum [3];

	// repacked result before the output register
	filter_pkg::pixel_t filtered;

	// channel field, zero extended
	function automatic int chan(input filter_pkg::pixel_t p, input int sel);
		case (sel)
			0: chan = int'(p[15:11]);
			1: chan = int'(p[10:5]);
			default: chan = int'(p[4:0]);
		endcase
	endfunction

	always_comb begin
		int centre_v;
		int edge_v;
		int corner_v;

		for (int c = 0; c < 3; c++) begin
			centre_v = chan(win_11, c);
			// four direct neighbours
			edge_v = chan(win_01, c) + chan(win_10, c) +
				chan(win_12, c) + chan(win_21, c);
			// diagonals
			corner_v = chan(win_00, c) + chan(win_02, c) +
				chan(win_20, c) + chan(win_22, c);
			ch_sum[c] = filter_pkg::w_centre * centre_v +
				filter_pkg::w_edge * edge_v +
				filter_pkg::w_corner * corner_v;
		end
	end

	// truncation wraps each channel modulo its own width
	assign filtered = {filter_pkg::red_t'(ch_sum[0]),
		filter_pkg::green_t'(ch_sum[1]),
		filter_pkg::red_t'(ch_sum[2])};

	// result register
	always_ff @(posedge clk) begin
		if (win_valid) begin
			pixel_out <= filtered;
		end
	end

	// output strobe, never held
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= win_valid;
		end
	end

endmodule

`default_nettype wire

//--- logic/line_buffer.sv
//**************************************************
// line buffer for the 3x3 window
// keeps two rows of history, emits column-aligned taps
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
	input wire clk,
	input wire reset,
	input wire filter_pkg::pixel_t pixel_in,
	input wire pix_valid,
	input wire frame_start,
	output logic tap_valid,
	output filter_pkg::pixel_t tap_cur,
	output filter_pkg::pixel_t tap_up1,
	output filter_pkg::pixel_t tap_up2,
	output logic tap_interior
);

	// position of the next expected pixel
	filter_pkg::col_t col_cnt;
	filter_pkg::row_t row_cnt;

	// position of the incoming pixel, frame_start forces 0,0
	filter_pkg::col_t cur_col;
	filter_pkg::row_t cur_row;
	filter_pkg::col_t next_col;
	filter_pkg::row_t next_row;
	logic last_col;

	// row -1 and row -2, indexed by column
	filter_pkg::pixel_t row1_mem [filter_pkg::line_len];
	filter_pkg::pixel_t row2_mem [filter_pkg::line_len];

	// old contents at the current column
	filter_pkg::pixel_t rd_up1;
	filter_pkg::pixel_t rd_up2;

	assign cur_col = frame_start ? '0 : col_cnt;
	assign cur_row = frame_start ? '0 : row_cnt;

	// wrap the column at the end of the line
	assign last_col = (cur_col == filter_pkg::col_t'(filter_pkg::line_len - 1));
	assign next_col = last_col ? '0 : cur_col + 1'b1;
	assign next_row = last_col ? cur_row + 1'b1 : cur_row;

	// read before write, same column
	assign rd_up1 = row1_mem[cur_col];
	assign rd_up2 = row2_mem[cur_col];

	// column and row counters
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pix_valid) begin
			col_cnt <= next_col;
			row_cnt <= next_row;
		end
	end

	// new pixel into row -1, old row -1 moves down to row -2
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			row1_mem[cur_col] <= pixel_in;
			row2_mem[cur_col] <= rd_up1;
		end
	end

	// column-aligned taps, one edge after the strobe
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			tap_cur <= pixel_in;
			tap_up1 <= rd_up1;
			tap_up2 <= rd_up2;
		end
	end

	// window centre sits one row up and one column left
	// so it is interior once both counts reach 2
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tap_valid <= 1'b0;
			tap_interior <= 1'b0;
		end else begin
			tap_valid <= pix_valid;
			if (pix_valid) begin
				tap_interior <= (cur_row >= filter_pkg::row_t'(2)) &&
					(cur_col >= filter_pkg::col_t'(2));
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/window_3x3.sv
//**************************************************
// 3x3 pixel window
// shifts left on each tap strobe, newest column on the right
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module window_3x3 (
	input wire clk,
	input wire reset,
	input wire tap_valid,
	input wire filter_pkg::pixel_t tap_cur,
	input wire filter_pkg::pixel_t tap_up1,
	input wire filter_pkg::pixel_t tap_up2,
	input wire tap_interior,
	output logic win_valid,
	// row 0 is two lines up, row 2 is the current line
	output filter_pkg::pixel_t win_00,
	output filter_pkg::pixel_t win_01,
	output filter_pkg::pixel_t win_02,
	output filter_pkg::pixel_t win_10,
	output filter_pkg::pixel_t win_11,
	output filter_pkg::pixel_t win_12,
	output filter_pkg::pixel_t win_20,
	output filter_pkg::pixel_t win_21,
	output filter_pkg::pixel_t win_22
);

	// window shift, only on a strobe so gaps do not disturb it
	always_ff @(posedge clk) begin
		if (tap_valid) begin
			// oldest row, from row -2
			win_00 <= win_01;
			win_01 <= win_02;
			win_02 <= tap_up2;

			// middle row holds the centre
			win_10 <= win_11;
			win_11 <= win_12;
			win_12 <= tap_up1;

			// incoming row
			win_20 <= win_21;
			win_21 <= win_22;
			win_22 <= tap_cur;
		end
	end

	// one-cycle strobe after an interior shift
	// border centres never raise it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= tap_valid & tap_interior;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the 3x3 filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f build.f --top-module filter_tb -o filter_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/filter_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "TEST PASS" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tests/filter_sva.sv
//**************************************************
// assertions for the 3x3 filter pipeline
// strobe latency and output state after reset
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module filter_sva (
	input wire clk,
	input wire reset,
	input wire pix_valid,
	input wire out_valid
);

	// output strobe stays low in the cycle after reset
	a_quiet_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// result three edges after the accepted pixel
	a_out_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(pix_valid, 3))
		else $error("out_valid not three edges after an accepted pixel");

endmodule

bind filter_top filter_sva u_filter_sva (
	.clk       (clk),
	.reset     (reset),
	.pix_valid (pix_valid),
	.out_valid (out_valid)
);

`default_nettype wire

//--- tests/filter_tb_tests.svh
//**************************************************
// directed tests for the 3x3 filter testbench
//**************************************************
`ifndef FILTER_TB_TESTS_SVH
`define FILTER_TB_TESTS_SVH

	// received results that are not zero
	function automatic int count_nonzero();
		int n;
		n = 0;
		foreach (got_q[i]) begin
			if (got_q[i] != '0) begin
				n++;
			end
		end
		return n;
	endfunction

	// one colour everywhere, weights cancel to zero
	task automatic test_flat();
		int n;
		start_test();
		fill_const(4, 16'h7bef);
		expect_frame(4);
		n = exp_q.size();
		send_pixels(4 * filter_pkg::line_len, 1'b0);
		wait_drain();
		check_count("out_valid count", out_cnt, 2 * (filter_pkg::line_len - 2));
		check_count("pixel_out nonzero", count_nonzero(), 0);
		finish_test("flat image", n);
	endtask

	// single bright pixel on black
	// centre plus four edge neighbours, corners weigh zero
	task automatic test_impulse();
		int n;
		start_test();
		fill_const(5, 16'h0000);
		img[2][360] = 16'h8c51;
		expect_frame(5);
		n = exp_q.size();
		send_pixels(5 * filter_pkg::line_len, 1'b0);
		wait_drain();
		check_count("pixel_out nonzero", count_nonzero(), 5);
		finish_test("impulse", n);
	endtask

	// back to back strobes, random pixels wrap every channel
	task automatic test_random();
		int n;
		start_test();
		fill_random(6);
		expect_frame(6);
		n = exp_q.size();
		send_pixels(6 * filter_pkg::line_len, 1'b0);
		wait_drain();
		first_run = got_q;
		finish_test("random image", n);
	endtask

	// same image again with idle cycles between strobes
	task automatic test_gaps();
		int n;
		start_test();
		expect_frame(6);
		n = exp_q.size();
		send_pixels(6 * filter_pkg::line_len, 1'b1);
		wait_drain();
		check_count("rerun length", got_q.size(), first_run.size());
		for (int i = 0; i < got_q.size() && i < first_run.size(); i++) begin
			check_pixel("pixel_out rerun", got_q[i], first_run[i]);
		end
		finish_test("gaps", n);
	endtask

	// old frame cut off halfway through its second line
	// too short for any interior centre, so nothing may come out of it
	task automatic test_restart();
		int n;
		start_test();
		fill_random(2);
		send_pixels(filter_pkg::line_len + filter_pkg::line_len / 2, 1'b0);
		fill_random(4);
		expect_frame(4);
		n = exp_q.size();
		send_pixels(4 * filter_pkg::line_len, 1'b0);
		wait_drain();
		finish_test("frame restart", n);
	endtask

`endif

//--- tests/filter_tb.sv
//**************************************************
// testbench for the 3x3 RGB565 filter
// image model, expected queue, LFSR pixels, watchdog
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module filter_tb;

	localparam int clk_half = 4;
	localparam int max_rows = 6;
	// pixels over all tests, restart test sends one and a half extra lines
	localparam int total_pix = (4 + 5 + 6 + 6 + 1 + 4) * filter_pkg::line_len +
		filter_pkg::line_len / 2;
	// three cycles per pixel plus room for reset and drains
	localparam int watchdog_ns = total_pix * 3 * 2 * clk_half + 20000;

	logic clk;
	logic reset;
	filter_pkg::pixel_t pixel_in;
	logic pix_valid;
	logic frame_start;
	filter_pkg::pixel_t pixel_out;
	logic out_valid;

	// source image, row major
	filter_pkg::pixel_t img [max_rows][filter_pkg::line_len];
	filter_pkg::pixel_t exp_q [$];
	filter_pkg::pixel_t got_q [$];
	// results of the back to back run
	filter_pkg::pixel_t first_run [$];

	logic [31:0] lfsr;
	integer err_cnt = 0;
	integer chk_cnt = 0;
	integer out_cnt = 0;
	integer test_cnt = 0;
	integer test_err0 = 0;

	filter_top u_filter_top (
		.clk         (clk),
		.reset       (reset),
		.pixel_in    (pixel_in),
		.pix_valid   (pix_valid),
		.frame_start (frame_start),
		.pixel_out   (pixel_out),
		.out_valid   (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_half) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$finish;
	end

	// galois step, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic out_bit;
		out_bit = lfsr[0];
		lfsr = lfsr >> 1;
		if (out_bit) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return out_bit;
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], lfsr_bit()};
		end
		return r;
	endfunction

	// weight by offset from the centre
	function automatic int weight(input int dr, input int dc);
		if (dr == 0 && dc == 0) begin
			return filter_pkg::w_centre;
		end else if (dr == 0 || dc == 0) begin
			return filter_pkg::w_edge;
		end
		return filter_pkg::w_corner;
	endfunction

	// expected filter output for centre r,c
	function automatic filter_pkg::pixel_t model_pixel(input int r, input int c);
		int sr;
		int sg;
		int sb;
		int w;
		filter_pkg::pixel_t p;
		sr = 0;
		sg = 0;
		sb = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				p = img[r + dr][c + dc];
				w = weight(dr, dc);
				sr += w * int'(p[15:11]);
				sg += w * int'(p[10:5]);
				sb += w * int'(p[4:0]);
			end
		end
		// each channel keeps only its own low bits
		return {filter_pkg::red_t'(sr & 31), filter_pkg::green_t'(sg & 63),
			filter_pkg::red_t'(sb & 31)};
	endfunction

	// interior centres only, raster order
	task automatic expect_frame(input int rows);
		for (int r = 1; r <= rows - 2; r++) begin
			for (int c = 1; c <= filter_pkg::line_len - 2; c++) begin
				exp_q.push_back(model_pixel(r, c));
			end
		end
	endtask

	task automatic fill_const(input int rows, input filter_pkg::pixel_t v);
		foreach (img[r, c]) begin
			if (r < rows) begin
				img[r][c] = v;
			end
		end
	endtask

	task automatic fill_random(input int rows);
		for (int r = 0; r < rows; r++) begin
			for (int c = 0; c < filter_pkg::line_len; c++) begin
				img[r][c] = rand_bits(16);
			end
		end
	endtask

	// raster order from 0,0, frame_start on the first pixel
	task automatic send_pixels(input int npix, input logic gaps);
		logic [15:0] idle;
		for (int i = 0; i < npix; i++) begin
			@(negedge clk);
			pixel_in = img[i / filter_pkg::line_len][i % filter_pkg::line_len];
			pix_valid = 1'b1;
			frame_start = (i == 0);
			if (gaps) begin
				idle = rand_bits(2);
				repeat (idle) begin
					@(negedge clk);
					pix_valid = 1'b0;
					frame_start = 1'b0;
				end
			end
		end
		@(negedge clk);
		pix_valid = 1'b0;
		frame_start = 1'b0;
	endtask

	task automatic check_pixel(input string name, input filter_pkg::pixel_t got,
		input filter_pkg::pixel_t exp_v);
		chk_cnt++;
		if (got !== exp_v) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp_v);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input integer got, input integer exp_v);
		chk_cnt++;
		if (got !== exp_v) begin
			$display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp_v);
			err_cnt++;
		end
	endtask

	// results are stable between rising edges
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			out_cnt++;
			got_q.push_back(pixel_out);
			if (exp_q.size() == 0) begin
				$display("unexpected output %h at %0t ns", pixel_out, $time);
				err_cnt++;
			end else begin
				check_pixel("pixel_out", pixel_out, exp_q.pop_front());
			end
		end
	end

	// wait for the queue to empty, then for any late strobe
	task automatic wait_drain();
		for (int i = 0; i < 64 && exp_q.size() != 0; i++) begin
			@(negedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected outputs never arrived", exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic start_test();
		test_err0 = err_cnt;
		out_cnt = 0;
		got_q.delete();
		exp_q.delete();
	endtask

	task automatic finish_test(input string name, input integer exp_total);
		check_count("out_valid count", out_cnt, exp_total);
		test_cnt++;
		$display("%s: %0d outputs, %0d errors", name, out_cnt, err_cnt - test_err0);
	endtask

	`include "filter_tb_tests.svh"

	initial begin
		reset = 1'b1;
		pixel_in = '0;
		pix_valid = 1'b0;
		frame_start = 1'b0;
		lfsr = 32'h6a95;
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_flat();
		test_impulse();
		test_random();
		test_gaps();
		test_restart();

		$display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
